// File: bench/ddr_port_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module ddr_port_model import dma_pkg::*; (
	input  wire                    clk,
	input  wire                    reset_d,
	input  wire                    stall_en_i,
	input  wire                    cmd_en_i,
	input  wire  [2:0]             cmd_instr_i,
	input  wire  [`DMA_ADDR_W-1:0] cmd_byte_addr_i,
	input  wire                    wr_en_i,
	input  wire  [`DMA_DATA_W-1:0] wr_data_i,
	input  wire                    rd_en_i,
	output logic                   cmd_full_o,
	output logic                   wr_full_o,
	output logic                   rd_empty_o,
	output logic [`DMA_DATA_W-1:0] rd_data_o
);

	logic [`DMA_DATA_W-1:0] mem [logic [`DMA_ADDR_W-1:0]];
	logic [`DMA_DATA_W-1:0] wr_q [$];
	logic [`DMA_DATA_W-1:0] rd_q [$];
	logic [31:0]            stall_lfsr;
	logic                   rd_stall;

	function automatic logic [31:0] stall_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Unwritten locations read back as X
	function automatic logic [`DMA_DATA_W-1:0] get_word(input logic [`DMA_ADDR_W-1:0] addr);
		return mem.exists(addr) ? mem[addr] : 'x;
	endfunction

	task automatic preload(input logic [`DMA_ADDR_W-1:0] addr, input logic [`DMA_DATA_W-1:0] data);
		mem[addr] = data;
	endtask

	initial begin
		cmd_full_o = 1'b0;
		wr_full_o  = 1'b0;
		rd_empty_o = 1'b1;
		rd_data_o  = '0;
		rd_stall   = 1'b0;
		stall_lfsr = 32'd99629;
	end

	always @(posedge clk) begin
		if (reset_d) begin
			wr_q.delete();
			rd_q.delete();
		end else begin
			if (rd_en_i && (rd_q.size() > 0))
				void'(rd_q.pop_front());
			if (wr_en_i)
				wr_q.push_back(wr_data_i);
			if (cmd_en_i && (cmd_instr_i == 3'(instr_write))) begin
				for (int i = 0; i < `DMA_BURST_LEN; i++)
					if (wr_q.size() > 0)
						mem[cmd_byte_addr_i + `DMA_ADDR_W'(4 * i)] = wr_q.pop_front();
			end else if (cmd_en_i && (cmd_instr_i == 3'(instr_read))) begin
				for (int i = 0; i < `DMA_BURST_LEN; i++)
					rd_q.push_back(get_word(cmd_byte_addr_i + `DMA_ADDR_W'(4 * i)));
			end
		end
		// Flags and head word change a little after the edge
		#2;
		if (stall_en_i) begin
			stall_lfsr = stall_step(stall_lfsr);
			cmd_full_o = stall_lfsr[0];
			stall_lfsr = stall_step(stall_lfsr);
			wr_full_o  = stall_lfsr[0];
			stall_lfsr = stall_step(stall_lfsr);
			rd_stall   = stall_lfsr[0];
		end else begin
			cmd_full_o = 1'b0;
			wr_full_o  = 1'b0;
			rd_stall   = 1'b0;
		end
		rd_empty_o = (rd_q.size() == 0) || rd_stall;
		rd_data_o  = (rd_q.size() > 0) ? rd_q[0] : '0;
	end

endmodule

`default_nettype wire

// File: bench/dma_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module dma_bridge_tb import dma_pkg::*; ();

	localparam int wait_limit   = 4000;
	localparam int op_write     = 0;
	localparam int op_read      = 1;
	localparam int op_both      = 2;
	localparam int op_prio      = 3;
	localparam int ob_max       = `DMA_FIFO_DEPTH - 1;
	localparam int ob_start_lim = `DMA_FIFO_DEPTH - 1 - `DMA_BURST_LEN;
	// Read bursts that start before the output buffer reaches the start threshold
	localparam int rd_fit = (ob_start_lim + `DMA_BURST_LEN - 1) / `DMA_BURST_LEN;
	localparam logic [`DMA_ADDR_W-1:0] addr_step = `DMA_ADDR_W'(4 * `DMA_BURST_LEN);

	typedef struct {
		int port;
		int op;
		int bursts;
		bit stall;
		bit calib;
	} row_t;

	logic                   clk;
	logic                   reset_d;
	logic                   calib_done;
	logic                   writes_en [2];
	logic                   reads_en [2];
	logic                   ib_push [2];
	logic [`DMA_DATA_W-1:0] ib_data [2];
	logic                   ob_pop [2];
	logic [`DMA_DATA_W-1:0] ob_data [2];
	logic                   ob_valid [2];
	logic [`DMA_CNT_W-1:0]  ob_count [2];
	logic                   cmd_full [2];
	logic                   cmd_en [2];
	ddr_instr_e             cmd_instr [2];
	logic [`DMA_ADDR_W-1:0] cmd_addr [2];
	logic                   wr_full [2];
	logic                   wr_en [2];
	logic [`DMA_DATA_W-1:0] wr_data [2];
	logic                   rd_empty [2];
	logic [`DMA_DATA_W-1:0] rd_data [2];
	logic                   rd_en [2];
	logic                   stall_en [2];

	logic [32:0]            cmd_log0 [$];
	logic [32:0]            cmd_log1 [$];
	logic [`DMA_DATA_W-1:0] wr_words [$];
	logic [`DMA_DATA_W-1:0] rd_words [$];
	logic [`DMA_ADDR_W-1:0] exp_wr_addr [2];
	logic [`DMA_ADDR_W-1:0] exp_rd_addr [2];
	logic [31:0]            lfsr_state;
	int                     errors;
	row_t                   rows [7];

	tb_clock u_clock (.clk(clk), .reset_d(reset_d));

	dma_bridge_top DUT (
		.clk(clk), .reset_d(reset_d), .calib_done_i(calib_done),
		.p0_writes_en_i(writes_en[0]), .p0_reads_en_i(reads_en[0]),
		.p0_ib_push_i(ib_push[0]), .p0_ib_data_i(ib_data[0]), .p0_ob_pop_i(ob_pop[0]),
		.p0_ob_data_o(ob_data[0]), .p0_ob_valid_o(ob_valid[0]), .p0_ob_count_o(ob_count[0]),
		.p0_cmd_full_i(cmd_full[0]), .p0_cmd_en_o(cmd_en[0]), .p0_cmd_instr_o(cmd_instr[0]),
		.p0_cmd_byte_addr_o(cmd_addr[0]), .p0_wr_full_i(wr_full[0]), .p0_wr_en_o(wr_en[0]),
		.p0_wr_data_o(wr_data[0]), .p0_rd_empty_i(rd_empty[0]), .p0_rd_data_i(rd_data[0]),
		.p0_rd_en_o(rd_en[0]),
		.p1_writes_en_i(writes_en[1]), .p1_reads_en_i(reads_en[1]),
		.p1_ib_push_i(ib_push[1]), .p1_ib_data_i(ib_data[1]), .p1_ob_pop_i(ob_pop[1]),
		.p1_ob_data_o(ob_data[1]), .p1_ob_valid_o(ob_valid[1]), .p1_ob_count_o(ob_count[1]),
		.p1_cmd_full_i(cmd_full[1]), .p1_cmd_en_o(cmd_en[1]), .p1_cmd_instr_o(cmd_instr[1]),
		.p1_cmd_byte_addr_o(cmd_addr[1]), .p1_wr_full_i(wr_full[1]), .p1_wr_en_o(wr_en[1]),
		.p1_wr_data_o(wr_data[1]), .p1_rd_empty_i(rd_empty[1]), .p1_rd_data_i(rd_data[1]),
		.p1_rd_en_o(rd_en[1])
	);

	ddr_port_model u_ddr0 (
		.clk(clk), .reset_d(reset_d), .stall_en_i(stall_en[0]), .cmd_en_i(cmd_en[0]),
		.cmd_instr_i(cmd_instr[0]), .cmd_byte_addr_i(cmd_addr[0]), .wr_en_i(wr_en[0]),
		.wr_data_i(wr_data[0]), .rd_en_i(rd_en[0]), .cmd_full_o(cmd_full[0]),
		.wr_full_o(wr_full[0]), .rd_empty_o(rd_empty[0]), .rd_data_o(rd_data[0])
	);

	ddr_port_model u_ddr1 (
		.clk(clk), .reset_d(reset_d), .stall_en_i(stall_en[1]), .cmd_en_i(cmd_en[1]),
		.cmd_instr_i(cmd_instr[1]), .cmd_byte_addr_i(cmd_addr[1]), .wr_en_i(wr_en[1]),
		.wr_data_i(wr_data[1]), .rd_en_i(rd_en[1]), .cmd_full_o(cmd_full[1]),
		.wr_full_o(wr_full[1]), .rd_empty_o(rd_empty[1]), .rd_data_o(rd_data[1])
	);

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per data bit
	function automatic logic [31:0] next_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] model_word(input int p, input logic [`DMA_ADDR_W-1:0] addr);
		return (p == 0) ? u_ddr0.get_word(addr) : u_ddr1.get_word(addr);
	endfunction

	// Commands seen on each port, as {instr, addr}
	always @(posedge clk) begin
		if (!reset_d) begin
			if (cmd_en[0])
				cmd_log0.push_back({cmd_instr[0], cmd_addr[0]});
			if (cmd_en[1])
				cmd_log1.push_back({cmd_instr[1], cmd_addr[1]});
			check_value("p0_ob_count_in_limit", 32'(ob_count[0] <= ob_max), 32'd1);
			check_value("p1_ob_count_in_limit", 32'(ob_count[1] <= ob_max), 32'd1);
		end
	end

	function automatic int log_size(input int p);
		return (p == 0) ? cmd_log0.size() : cmd_log1.size();
	endfunction

	task automatic wait_cmd(input int p, output logic [2:0] instr, output logic [29:0] addr);
		int n;
		logic [32:0] ent;
		n = 0;
		ent = '1;
		while ((log_size(p) == 0) && (n < wait_limit)) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (log_size(p) == 0) begin
			errors++;
			$display("Port %0d issued no command within %0d cycles", p, wait_limit);
		end else if (p == 0) begin
			ent = cmd_log0.pop_front();
		end else begin
			ent = cmd_log1.pop_front();
		end
		instr = ent[32:30];
		addr = ent[29:0];
	endtask

	task automatic push_words(input int p, input int count);
		for (int i = 0; i < count; i++) begin
			ib_push[p] = 1'b1;
			ib_data[p] = next_word();
			wr_words.push_back(ib_data[p]);
			@(posedge clk);
			#2;
		end
		ib_push[p] = 1'b0;
	endtask

	// Each write command must land the pushed words in order
	task automatic expect_write_cmds(input int p, input int n);
		logic [2:0] instr;
		logic [29:0] addr;
		for (int b = 0; b < n; b++) begin
			wait_cmd(p, instr, addr);
			check_value($sformatf("p%0d_cmd_instr", p), 32'(instr), 32'(instr_write));
			check_value($sformatf("p%0d_cmd_byte_addr", p), 32'(addr), 32'(exp_wr_addr[p]));
			for (int i = 0; i < `DMA_BURST_LEN; i++)
				check_value($sformatf("p%0d_mem_word", p),
					model_word(p, exp_wr_addr[p] + `DMA_ADDR_W'(4 * i)), wr_words.pop_front());
			exp_wr_addr[p] = exp_wr_addr[p] + addr_step;
		end
	endtask

	task automatic preload_reads(input int p, input int n);
		logic [31:0] w;
		for (int i = 0; i < n * `DMA_BURST_LEN; i++) begin
			w = next_word();
			rd_words.push_back(w);
			if (p == 0)
				u_ddr0.preload(exp_rd_addr[p] + `DMA_ADDR_W'(4 * i), w);
			else
				u_ddr1.preload(exp_rd_addr[p] + `DMA_ADDR_W'(4 * i), w);
		end
	endtask

	task automatic expect_read_cmds(input int p, input int n);
		logic [2:0] instr;
		logic [29:0] addr;
		for (int b = 0; b < n; b++) begin
			wait_cmd(p, instr, addr);
			check_value($sformatf("p%0d_cmd_instr", p), 32'(instr), 32'(instr_read));
			check_value($sformatf("p%0d_cmd_byte_addr", p), 32'(addr), 32'(exp_rd_addr[p]));
			exp_rd_addr[p] = exp_rd_addr[p] + addr_step;
		end
	endtask

	task automatic wait_ob_fill(input int p, input int words);
		int n;
		n = 0;
		while ((ob_count[p] < words) && (n < wait_limit)) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (ob_count[p] < words) begin
			errors++;
			$display("Output buffer of port %0d did not fill to %0d words", p, words);
		end
	endtask

	task automatic pop_words(input int p, input int count);
		int n;
		for (int i = 0; i < count; i++) begin
			n = 0;
			while ((ob_count[p] == '0) && (n < wait_limit)) begin
				@(posedge clk);
				#2;
				n++;
			end
			if (ob_count[p] == '0) begin
				errors++;
				$display("Output buffer of port %0d stayed empty at word %0d", p, i);
				return;
			end
			ob_pop[p] = 1'b1;
			@(posedge clk);
			#2;
			ob_pop[p] = 1'b0;
			check_value($sformatf("p%0d_ob_valid", p), 32'(ob_valid[p]), 32'd1);
			check_value($sformatf("p%0d_ob_data", p), ob_data[p], rd_words.pop_front());
		end
	endtask

	task automatic write_row(input int p, input int n, input bit calib);
		writes_en[p] = 1'b1;
		push_words(p, n * `DMA_BURST_LEN);
		if (!calib) begin
			// No transfer may start while calibration is low
			repeat (200) begin
				@(posedge clk);
				#2;
			end
			check_value($sformatf("p%0d_cmds_before_calib", p), 32'(log_size(p)), 32'd0);
			calib_done = 1'b1;
		end
		expect_write_cmds(p, n);
		writes_en[p] = 1'b0;
	endtask

	// Reads pause once the output buffer passes the start threshold
	// One more burst then fits after a burst has been popped
	task automatic read_row(input int p, input int n);
		int first;
		int popped;
		first = (n < rd_fit) ? n : rd_fit;
		popped = 0;
		preload_reads(p, n);
		reads_en[p] = 1'b1;
		expect_read_cmds(p, first);
		if (n > first) begin
			wait_ob_fill(p, first * `DMA_BURST_LEN);
			repeat (100) begin
				@(posedge clk);
				#2;
			end
			check_value($sformatf("p%0d_cmds_above_threshold", p), 32'(log_size(p)), 32'd0);
			pop_words(p, `DMA_BURST_LEN);
			popped = `DMA_BURST_LEN;
			expect_read_cmds(p, n - first);
		end
		reads_en[p] = 1'b0;
		pop_words(p, n * `DMA_BURST_LEN - popped);
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		int n;
		errors = 0;
		lfsr_state = 32'd99629;
		calib_done = 1'b0;
		for (int p = 0; p < 2; p++) begin
			writes_en[p] = 1'b0;
			reads_en[p] = 1'b0;
			ib_push[p] = 1'b0;
			ib_data[p] = '0;
			ob_pop[p] = 1'b0;
			stall_en[p] = 1'b0;
			exp_wr_addr[p] = '0;
			exp_rd_addr[p] = '0;
		end
		rows[0] = '{0, op_write, 2, 1'b0, 1'b1};
		rows[1] = '{0, op_read, 4, 1'b0, 1'b1};
		rows[2] = '{1, op_write, 2, 1'b1, 1'b1};
		rows[3] = '{1, op_read, 2, 1'b1, 1'b1};
		rows[4] = '{1, op_write, 1, 1'b0, 1'b0};
		rows[5] = '{0, op_both, 1, 1'b1, 1'b1};
		rows[6] = '{1, op_prio, 1, 1'b0, 1'b1};

		n = 0;
		#2;
		while (reset_d && (n < 20)) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (reset_d) begin
			errors++;
			$display("Reset was never released");
		end

		// Quiet outputs after reset
		repeat (10) begin
			for (int p = 0; p < 2; p++) begin
				check_value($sformatf("p%0d_cmd_en", p), 32'(cmd_en[p]), 32'd0);
				check_value($sformatf("p%0d_wr_en", p), 32'(wr_en[p]), 32'd0);
				check_value($sformatf("p%0d_rd_en", p), 32'(rd_en[p]), 32'd0);
				check_value($sformatf("p%0d_ob_valid", p), 32'(ob_valid[p]), 32'd0);
				check_value($sformatf("p%0d_ob_count", p), 32'(ob_count[p]), 32'd0);
			end
			@(posedge clk);
			#2;
		end

		for (int r = 0; r < 7; r++) begin
			calib_done = rows[r].calib;
			stall_en[0] = rows[r].stall;
			stall_en[1] = rows[r].stall;
			case (rows[r].op)
				op_write: write_row(rows[r].port, rows[r].bursts, rows[r].calib);
				op_read:  read_row(rows[r].port, rows[r].bursts);
				op_both: begin
					fork
						write_row(0, rows[r].bursts, 1'b1);
						read_row(1, rows[r].bursts);
					join
				end
				default: begin
					// Both directions qualify at once, write goes first
					// This port has written and read as many bursts as each other,
					// so the read lands on the burst just written
					push_words(rows[r].port, `DMA_BURST_LEN);
					foreach (wr_words[i])
						rd_words.push_back(wr_words[i]);
					writes_en[rows[r].port] = 1'b1;
					reads_en[rows[r].port] = 1'b1;
					expect_write_cmds(rows[r].port, 1);
					expect_read_cmds(rows[r].port, 1);
					writes_en[rows[r].port] = 1'b0;
					reads_en[rows[r].port] = 1'b0;
					pop_words(rows[r].port, `DMA_BURST_LEN);
				end
			endcase
			stall_en[0] = 1'b0;
			stall_en[1] = 1'b0;
			repeat (20) @(posedge clk);
			#2;
		end

		check_value("p0_extra_cmds", 32'(log_size(0)), 32'd0);
		check_value("p1_extra_cmds", 32'(log_size(1)), 32'd0);
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/dma_port_sva.sv
`timescale 1ns/10ps
`default_nettype none

module dma_port_sva (
	input wire clk,
	input wire reset_d,
	input wire cmd_en_o,
	input wire cmd_full_i,
	input wire wr_en_o,
	input wire wr_full_i,
	input wire rd_en_o,
	input wire rd_empty_i
);

	// Strobes respect the controller flags
	a_cmd_not_full: assert property (@(posedge clk) disable iff (reset_d)
		cmd_en_o |-> !cmd_full_i) else $error("cmd_en_o high while cmd_full_i high");
	a_wr_not_full: assert property (@(posedge clk) disable iff (reset_d)
		wr_en_o |-> !wr_full_i) else $error("wr_en_o high while wr_full_i high");
	a_rd_not_empty: assert property (@(posedge clk) disable iff (reset_d)
		rd_en_o |-> !rd_empty_i) else $error("rd_en_o high while rd_empty_i high");

	// One command per pulse
	a_cmd_pulse: assert property (@(posedge clk) disable iff (reset_d)
		cmd_en_o |=> !cmd_en_o) else $error("cmd_en_o held for more than one cycle");

	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(reset_d) |-> (!cmd_en_o && !wr_en_o && !rd_en_o))
		else $error("strobe active in the first cycle after reset");

endmodule

bind dma_port dma_port_sva u_sva (
	.clk        (clk),
	.reset_d    (reset_d),
	.cmd_en_o   (cmd_en_o),
	.cmd_full_i (cmd_full_i),
	.wr_en_o    (wr_en_o),
	.wr_full_i  (wr_full_i),
	.rd_en_o    (rd_en_o),
	.rd_empty_i (rd_empty_i)
);

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset_d
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held for five rising edges, released just after the fifth
	initial begin
		reset_d = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset_d = 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/burst_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module burst_counter (
	input  wire  clk,
	input  wire  reset_d,
	input  wire  load_i,
	input  wire  dec_i,
	output logic done_o
);

	localparam int cnt_w = $clog2(`DMA_BURST_LEN + 1);
	localparam logic [cnt_w-1:0] burst_words = cnt_w'(`DMA_BURST_LEN);

	logic [cnt_w-1:0] cnt_q;

	// Words still to move in the current burst
	always_ff @(posedge clk) begin
		if (reset_d) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= burst_words;
		end else if (dec_i && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign done_o = (cnt_q == '0);

endmodule

`default_nettype wire

// File: logic/dma_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module dma_bridge_top import dma_pkg::*; (
	input  wire                    clk,
	input  wire                    reset_d,
	input  wire                    calib_done_i,
	// ------------------------------------------------------------
	// Port 0
	input  wire                    p0_writes_en_i,
	input  wire                    p0_reads_en_i,
	input  wire                    p0_ib_push_i,
	input  wire  [`DMA_DATA_W-1:0] p0_ib_data_i,
	input  wire                    p0_ob_pop_i,
	output logic [`DMA_DATA_W-1:0] p0_ob_data_o,
	output logic                   p0_ob_valid_o,
	output logic [`DMA_CNT_W-1:0]  p0_ob_count_o,
	input  wire                    p0_cmd_full_i,
	output logic                   p0_cmd_en_o,
	output ddr_instr_e             p0_cmd_instr_o,
	output logic [`DMA_ADDR_W-1:0] p0_cmd_byte_addr_o,
	input  wire                    p0_wr_full_i,
	output logic                   p0_wr_en_o,
	output logic [`DMA_DATA_W-1:0] p0_wr_data_o,
	input  wire                    p0_rd_empty_i,
	input  wire  [`DMA_DATA_W-1:0] p0_rd_data_i,
	output logic                   p0_rd_en_o,
	// ------------------------------------------------------------
	// Port 1
	input  wire                    p1_writes_en_i,
	input  wire                    p1_reads_en_i,
	input  wire                    p1_ib_push_i,
	input  wire  [`DMA_DATA_W-1:0] p1_ib_data_i,
	input  wire                    p1_ob_pop_i,
	output logic [`DMA_DATA_W-1:0] p1_ob_data_o,
	output logic                   p1_ob_valid_o,
	output logic [`DMA_CNT_W-1:0]  p1_ob_count_o,
	input  wire                    p1_cmd_full_i,
	output logic                   p1_cmd_en_o,
	output ddr_instr_e             p1_cmd_instr_o,
	output logic [`DMA_ADDR_W-1:0] p1_cmd_byte_addr_o,
	input  wire                    p1_wr_full_i,
	output logic                   p1_wr_en_o,
	output logic [`DMA_DATA_W-1:0] p1_wr_data_o,
	input  wire                    p1_rd_empty_i,
	input  wire  [`DMA_DATA_W-1:0] p1_rd_data_i,
	output logic                   p1_rd_en_o
);

	logic calib_q;

	// Calibration status from the controller, shared by both ports
	always_ff @(posedge clk) begin
		if (reset_d)
			calib_q <= 1'b0;
		else
			calib_q <= calib_done_i;
	end

	dma_port u_p0 (
		.clk             (clk),
		.reset_d         (reset_d),
		.calib_done_i    (calib_q),
		.writes_en_i     (p0_writes_en_i),
		.reads_en_i      (p0_reads_en_i),
		.ib_push_i       (p0_ib_push_i),
		.ib_data_i       (p0_ib_data_i),
		.ob_pop_i        (p0_ob_pop_i),
		.ob_data_o       (p0_ob_data_o),
		.ob_valid_o      (p0_ob_valid_o),
		.ob_count_o      (p0_ob_count_o),
		.cmd_full_i      (p0_cmd_full_i),
		.cmd_en_o        (p0_cmd_en_o),
		.cmd_instr_o     (p0_cmd_instr_o),
		.cmd_byte_addr_o (p0_cmd_byte_addr_o),
		.wr_full_i       (p0_wr_full_i),
		.wr_en_o         (p0_wr_en_o),
		.wr_data_o       (p0_wr_data_o),
		.rd_empty_i      (p0_rd_empty_i),
		.rd_data_i       (p0_rd_data_i),
		.rd_en_o         (p0_rd_en_o)
	);

	dma_port u_p1 (
		.clk             (clk),
		.reset_d         (reset_d),
		.calib_done_i    (calib_q),
		.writes_en_i     (p1_writes_en_i),
		.reads_en_i      (p1_reads_en_i),
		.ib_push_i       (p1_ib_push_i),
		.ib_data_i       (p1_ib_data_i),
		.ob_pop_i        (p1_ob_pop_i),
		.ob_data_o       (p1_ob_data_o),
		.ob_valid_o      (p1_ob_valid_o),
		.ob_count_o      (p1_ob_count_o),
		.cmd_full_i      (p1_cmd_full_i),
		.cmd_en_o        (p1_cmd_en_o),
		.cmd_instr_o     (p1_cmd_instr_o),
		.cmd_byte_addr_o (p1_cmd_byte_addr_o),
		.wr_full_i       (p1_wr_full_i),
		.wr_en_o         (p1_wr_en_o),
		.wr_data_o       (p1_wr_data_o),
		.rd_empty_i      (p1_rd_empty_i),
		.rd_data_i       (p1_rd_data_i),
		.rd_en_o         (p1_rd_en_o)
	);

endmodule

`default_nettype wire

// File: logic/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Words moved per controller command
`define DMA_BURST_LEN 32

// Depth of the user-side input and output buffers in words
`define DMA_FIFO_DEPTH 128

// Fill count width, wide enough to hold a full buffer
`define DMA_CNT_W 8

// Controller byte address width
`define DMA_ADDR_W 30

// User and controller data word width
`define DMA_DATA_W 32

`endif

// File: logic/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// Port sequencer states
	typedef enum logic [2:0] {
		idle     = 3'd0,
		wr_fetch = 3'd1,
		wr_push  = 3'd2,
		wr_check = 3'd3,
		rd_cmd   = 3'd4,
		rd_wait  = 3'd5,
		rd_move  = 3'd6,
		rd_check = 3'd7
	} dma_state_e;

	// DDR controller command instruction
	typedef enum logic [2:0] {
		instr_write = 3'd0,
		instr_read  = 3'd1
	} ddr_instr_e;

endpackage

`default_nettype wire

// File: logic/dma_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module dma_port import dma_pkg::*; (
	input  wire                    clk,
	input  wire                    reset_d,
	input  wire                    calib_done_i,
	input  wire                    writes_en_i,
	input  wire                    reads_en_i,
	input  wire                    ib_push_i,
	input  wire  [`DMA_DATA_W-1:0] ib_data_i,
	input  wire                    ob_pop_i,
	output logic [`DMA_DATA_W-1:0] ob_data_o,
	output logic                   ob_valid_o,
	output logic [`DMA_CNT_W-1:0]  ob_count_o,
	input  wire                    cmd_full_i,
	output logic                   cmd_en_o,
	output ddr_instr_e             cmd_instr_o,
	output logic [`DMA_ADDR_W-1:0] cmd_byte_addr_o,
	input  wire                    wr_full_i,
	output logic                   wr_en_o,
	output logic [`DMA_DATA_W-1:0] wr_data_o,
	input  wire                    rd_empty_i,
	input  wire  [`DMA_DATA_W-1:0] rd_data_i,
	output logic                   rd_en_o
);

	logic                   ib_pop;
	logic                   ib_valid;
	logic [`DMA_DATA_W-1:0] ib_rdata;
	logic [`DMA_CNT_W-1:0]  ib_count;
	logic                   ob_push;
	logic [`DMA_DATA_W-1:0] ob_wdata;
	logic                   burst_load;
	logic                   burst_dec;
	logic                   burst_done;

	// Input buffer collects user results bound for DDR
	word_fifo u_ib (
		.clk     (clk),
		.reset_d (reset_d),
		.push_i  (ib_push_i),
		.data_i  (ib_data_i),
		.pop_i   (ib_pop),
		.data_o  (ib_rdata),
		.valid_o (ib_valid),
		.count_o (ib_count),
		.empty_o ()
	);

	// Output buffer holds words read back from DDR
	word_fifo u_ob (
		.clk     (clk),
		.reset_d (reset_d),
		.push_i  (ob_push),
		.data_i  (ob_wdata),
		.pop_i   (ob_pop_i),
		.data_o  (ob_data_o),
		.valid_o (ob_valid_o),
		.count_o (ob_count_o),
		.empty_o ()
	);

	burst_counter u_burst (
		.clk     (clk),
		.reset_d (reset_d),
		.load_i  (burst_load),
		.dec_i   (burst_dec),
		.done_o  (burst_done)
	);

	dma_port_fsm u_fsm (
		.clk             (clk),
		.reset_d         (reset_d),
		.calib_done_i    (calib_done_i),
		.writes_en_i     (writes_en_i),
		.reads_en_i      (reads_en_i),
		.ib_count_i      (ib_count),
		.ib_valid_i      (ib_valid),
		.ib_data_i       (ib_rdata),
		.ob_count_i      (ob_count_o),
		.burst_done_i    (burst_done),
		.cmd_full_i      (cmd_full_i),
		.wr_full_i       (wr_full_i),
		.rd_empty_i      (rd_empty_i),
		.rd_data_i       (rd_data_i),
		.ib_pop_o        (ib_pop),
		.ob_push_o       (ob_push),
		.ob_data_o       (ob_wdata),
		.burst_load_o    (burst_load),
		.burst_dec_o     (burst_dec),
		.cmd_en_o        (cmd_en_o),
		.cmd_instr_o     (cmd_instr_o),
		.cmd_byte_addr_o (cmd_byte_addr_o),
		.wr_en_o         (wr_en_o),
		.wr_data_o       (wr_data_o),
		.rd_en_o         (rd_en_o)
	);

endmodule

`default_nettype wire

// File: logic/dma_port_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module dma_port_fsm import dma_pkg::*; (
	input  wire                    clk,
	input  wire                    reset_d,
	input  wire                    calib_done_i,
	input  wire                    writes_en_i,
	input  wire                    reads_en_i,
	input  wire  [`DMA_CNT_W-1:0]  ib_count_i,
	input  wire                    ib_valid_i,
	input  wire  [`DMA_DATA_W-1:0] ib_data_i,
	input  wire  [`DMA_CNT_W-1:0]  ob_count_i,
	input  wire                    burst_done_i,
	input  wire                    cmd_full_i,
	input  wire                    wr_full_i,
	input  wire                    rd_empty_i,
	input  wire  [`DMA_DATA_W-1:0] rd_data_i,
	output logic                   ib_pop_o,
	output logic                   ob_push_o,
	output logic [`DMA_DATA_W-1:0] ob_data_o,
	output logic                   burst_load_o,
	output logic                   burst_dec_o,
	output logic                   cmd_en_o,
	output ddr_instr_e             cmd_instr_o,
	output logic [`DMA_ADDR_W-1:0] cmd_byte_addr_o,
	output logic                   wr_en_o,
	output logic [`DMA_DATA_W-1:0] wr_data_o,
	output logic                   rd_en_o
);

	localparam logic [`DMA_CNT_W-1:0] burst_words = `DMA_CNT_W'(`DMA_BURST_LEN);
	localparam logic [`DMA_CNT_W-1:0] ob_limit =
		`DMA_CNT_W'(`DMA_FIFO_DEPTH - 1 - `DMA_BURST_LEN);
	// One burst of 32-bit words in bytes
	localparam logic [`DMA_ADDR_W-1:0] addr_step = `DMA_ADDR_W'(4 * `DMA_BURST_LEN);

	dma_state_e             state_q;
	logic                   write_mode_q;
	logic                   read_mode_q;
	logic [`DMA_ADDR_W-1:0] wr_addr_q;
	logic [`DMA_ADDR_W-1:0] rd_addr_q;
	logic                   wr_hold_q;
	logic [`DMA_DATA_W-1:0] wr_data_q;
	logic [`DMA_DATA_W-1:0] ob_data_q;
	logic                   start_wr;
	logic                   start_rd;
	logic                   word_rdy;
	logic                   wr_cmd_go;
	logic                   rd_cmd_go;

	// ------------------------------------------------------------
	// Start conditions and strobes
	// ------------------------------------------------------------
	assign start_wr = calib_done_i && write_mode_q && (ib_count_i >= burst_words);
	assign start_rd = calib_done_i && read_mode_q && (ob_count_i < ob_limit);

	// Word is ready in its valid cycle, or held while the write FIFO is full
	assign word_rdy = ib_valid_i || wr_hold_q;

	assign wr_cmd_go = (state_q == wr_check) && burst_done_i && !cmd_full_i;
	assign rd_cmd_go = (state_q == rd_cmd) && !cmd_full_i;

	assign ib_pop_o     = (state_q == wr_fetch);
	assign wr_en_o      = (state_q == wr_push) && word_rdy && !wr_full_i;
	assign wr_data_o    = wr_hold_q ? wr_data_q : ib_data_i;
	assign rd_en_o      = (state_q == rd_move) && !rd_empty_i;
	assign ob_push_o    = rd_en_o;
	assign ob_data_o    = ob_data_q;
	assign burst_load_o = (state_q == idle) && (start_wr || start_rd);
	assign burst_dec_o  = wr_en_o || rd_en_o;

	assign cmd_en_o        = wr_cmd_go || rd_cmd_go;
	assign cmd_instr_o     = (state_q == rd_cmd) ? instr_read : instr_write;
	assign cmd_byte_addr_o = (state_q == rd_cmd) ? rd_addr_q : wr_addr_q;

	// ------------------------------------------------------------
	// Burst sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset_d) begin
			state_q      <= idle;
			write_mode_q <= 1'b0;
			read_mode_q  <= 1'b0;
			wr_addr_q    <= '0;
			rd_addr_q    <= '0;
			wr_hold_q    <= 1'b0;
		end else begin
			write_mode_q <= writes_en_i;
			read_mode_q  <= reads_en_i;
			case (state_q)
				idle: begin
					// Write wins when both directions qualify
					if (start_wr)
						state_q <= wr_fetch;
					else if (start_rd)
						state_q <= rd_cmd;
				end
				wr_fetch: begin
					state_q <= wr_push;
				end
				wr_push: begin
					if (wr_en_o) begin
						wr_hold_q <= 1'b0;
						state_q   <= wr_check;
					end else if (ib_valid_i) begin
						wr_hold_q <= 1'b1;
					end
				end
				wr_check: begin
					if (!burst_done_i) begin
						state_q <= wr_fetch;
					end else if (!cmd_full_i) begin
						wr_addr_q <= wr_addr_q + addr_step;
						state_q   <= idle;
					end
				end
				rd_cmd: begin
					if (!cmd_full_i) begin
						rd_addr_q <= rd_addr_q + addr_step;
						state_q   <= rd_wait;
					end
				end
				rd_wait: begin
					if (!rd_empty_i)
						state_q <= rd_move;
				end
				rd_move: begin
					if (rd_en_o)
						state_q <= rd_check;
				end
				rd_check: begin
					state_q <= burst_done_i ? idle : rd_wait;
				end
				default: begin
					state_q <= idle;
				end
			endcase
		end
	end

	// Data capture, the FWFT head stays put until rd_en_o takes it
	always_ff @(posedge clk) begin
		if ((state_q == wr_push) && ib_valid_i)
			wr_data_q <= ib_data_i;
		if ((state_q == rd_wait) && !rd_empty_i)
			ob_data_q <= rd_data_i;
	end

endmodule

`default_nettype wire

// File: logic/word_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module word_fifo (
	input  wire                   clk,
	input  wire                   reset_d,
	input  wire                   push_i,
	input  wire [`DMA_DATA_W-1:0] data_i,
	input  wire                   pop_i,
	output logic [`DMA_DATA_W-1:0] data_o,
	output logic                  valid_o,
	output logic [`DMA_CNT_W-1:0] count_o,
	output logic                  empty_o
);

	localparam int ptr_w = $clog2(`DMA_FIFO_DEPTH);
	localparam logic [`DMA_CNT_W-1:0] full_count = `DMA_CNT_W'(`DMA_FIFO_DEPTH);

	logic [`DMA_DATA_W-1:0] mem [`DMA_FIFO_DEPTH];
	logic [ptr_w-1:0]       wr_ptr_q;
	logic [ptr_w-1:0]       rd_ptr_q;
	logic [`DMA_CNT_W-1:0]  count_q;
	logic                   do_push;
	logic                   do_pop;

	// Pushes into a full buffer and pops from an empty one are dropped
	assign do_push = push_i && (count_q != full_count);
	assign do_pop  = pop_i && (count_q != '0);

	assign count_o = count_q;
	assign empty_o = (count_q == '0);

	// Pointers, fill count and the read strobe
	always_ff @(posedge clk) begin
		if (reset_d) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			valid_o  <= 1'b0;
		end else begin
			valid_o <= do_pop;
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Storage and registered head word
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr_q] <= data_i;
		if (do_pop)
			data_o <= mem[rd_ptr_q];
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/dma_pkg.sv
logic/word_fifo.sv
logic/burst_counter.sv
logic/dma_port_fsm.sv
logic/dma_port.sv
logic/dma_bridge_top.sv
bench/tb_clock.sv
bench/ddr_port_model.sv
bench/dma_port_sva.sv
bench/dma_bridge_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DMA bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module dma_bridge_tb -o dma_sim > build.log 2>&1 &&
	./obj_dir/dma_sim > sim.log 2>&1 ||
	{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log &&
	{ echo "Simulation reported failure, see sim.log"; exit 1; } ||
	{ echo "Simulation finished without failure"; exit 0; }
